// File: logic/bus_defines.svh
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// Forward bus word and payload widths
`define BUS_ADDR_W 16
`define BUS_DATA_W 8

// Address bit that picks the target
// 0 selects target 1, 1 selects target 2
`define BUS_TSEL_BIT 15

// Targets behind the shared bus
`define BUS_NUM_TARGETS 2

`endif

// File: logic/bus_pkg.sv
`include "bus_defines.svh"

package bus_pkg;

    // Kind of beat on the forward word
    typedef enum logic {
        BEAT_ADDR = 1'b0,
        BEAT_DATA = 1'b1
    } beat_kind_t;

    // Forward bus word, read as address or as write data
    typedef union packed {
        struct packed {
            logic                      tsel;
            logic [`BUS_TSEL_BIT-1:0]  offset;
        } addr;
        struct packed {
            logic [`BUS_ADDR_W-`BUS_DATA_W-1:0] unused;
            logic [`BUS_DATA_W-1:0]             data;
        } data;
    } bus_word_u;

endpackage

// File: logic/owner_pkg.sv
package owner_pkg;

    // Initiator currently holding the bus
    typedef enum logic [1:0] {
        OWNER_NONE  = 2'b00,
        OWNER_INIT1 = 2'b01,
        OWNER_INIT2 = 2'b10
    } owner_t;

endpackage

// File: logic/init_port.sv
`include "bus_defines.svh"

module init_port import bus_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req,
    input  logic [`BUS_ADDR_W-1:0] addr,
    input  logic [`BUS_DATA_W-1:0] data,
    input  logic                   rw,
    input  logic                   grant,
    output logic                   arb_req,
    output bus_word_u              fwd_word,
    output beat_kind_t             fwd_kind,
    output logic                   fwd_valid,
    output logic                   fwd_rw,
    output logic                   init_grant,
    output logic                   init_ack,
    output logic [`BUS_DATA_W-1:0] init_data_in,
    output logic                   init_data_in_valid,
    input  logic                   ret_ack,
    input  logic [`BUS_DATA_W-1:0] ret_data,
    input  logic                   ret_valid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_WAIT
    } state_t;

    state_t                 state;
    logic [`BUS_ADDR_W-1:0] addr_q;
    logic [`BUS_DATA_W-1:0] data_q;
    logic                   rw_q;
    logic [`BUS_DATA_W-1:0] rdata_q;
    logic                   beat_addr;
    logic                   beat_data;

    assign beat_addr = grant && (state == ST_ADDR);
    assign beat_data = grant && (state == ST_DATA);

    // Only asks while the address beat is still pending
    assign arb_req = (state == ST_ADDR);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: if (req) state <= ST_ADDR;
                ST_ADDR: if (grant) state <= rw_q ? ST_DATA : ST_WAIT;
                ST_DATA: state <= ST_WAIT;
                ST_WAIT: if (ret_ack) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Request fields held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            addr_q <= addr;
            data_q <= data;
            rw_q   <= rw;
        end
        if (ret_valid) begin
            rdata_q <= ret_data;
        end
    end

    always_comb begin
        fwd_word = '0;
        fwd_kind = BEAT_ADDR;
        if (beat_data) begin
            fwd_word.data.data = data_q;
            fwd_kind           = BEAT_DATA;
        end else begin
            fwd_word.addr.tsel   = addr_q[`BUS_TSEL_BIT];
            fwd_word.addr.offset = addr_q[`BUS_TSEL_BIT-1:0];
        end
    end

    assign fwd_valid = beat_addr || beat_data;
    assign fwd_rw    = rw_q;

    assign init_grant         = grant;
    assign init_ack           = ret_ack && (state == ST_WAIT);
    assign init_data_in_valid = init_ack && ret_valid;
    assign init_data_in       = ret_valid ? ret_data : rdata_q;

endmodule

// File: logic/bus_arbiter.sv
`include "bus_defines.svh"

module bus_arbiter import bus_pkg::*, owner_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       arb_req1,
    input  bus_word_u  fwd_word1,
    input  beat_kind_t fwd_kind1,
    input  logic       fwd_valid1,
    input  logic       fwd_rw1,
    input  logic       arb_req2,
    input  bus_word_u  fwd_word2,
    input  beat_kind_t fwd_kind2,
    input  logic       fwd_valid2,
    input  logic       fwd_rw2,
    input  logic       txn_done,
    output logic       grant1,
    output logic       grant2,
    output owner_t     owner,
    output bus_word_u  fwd_word,
    output beat_kind_t fwd_kind,
    output logic       fwd_valid,
    output logic       fwd_rw
);

    // Initiator 1 wins a tie on an idle bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner <= OWNER_NONE;
        end else if (owner == OWNER_NONE) begin
            if (arb_req1) begin
                owner <= OWNER_INIT1;
            end else if (arb_req2) begin
                owner <= OWNER_INIT2;
            end
        end else if (txn_done) begin
            owner <= OWNER_NONE;
        end
    end

    assign grant1 = (owner == OWNER_INIT1);
    assign grant2 = (owner == OWNER_INIT2);

    // Shared forward bus
    always_comb begin
        fwd_word  = '0;
        fwd_kind  = BEAT_ADDR;
        fwd_valid = 1'b0;
        fwd_rw    = 1'b0;
        case (owner)
            OWNER_INIT1: begin
                fwd_word  = fwd_word1;
                fwd_kind  = fwd_kind1;
                fwd_valid = fwd_valid1;
                fwd_rw    = fwd_rw1;
            end
            OWNER_INIT2: begin
                fwd_word  = fwd_word2;
                fwd_kind  = fwd_kind2;
                fwd_valid = fwd_valid2;
                fwd_rw    = fwd_rw2;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/addr_decoder.sv
`include "bus_defines.svh"

module addr_decoder import bus_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  bus_word_u                   fwd_word,
    input  beat_kind_t                  fwd_kind,
    input  logic                        fwd_valid,
    input  logic                        txn_done,
    output logic [`BUS_NUM_TARGETS-1:0] tsel_valid
);

    logic [`BUS_NUM_TARGETS-1:0] sel_now;
    logic [`BUS_NUM_TARGETS-1:0] sel_q;

    // One-hot pick from the select bit of an address beat
    always_comb begin
        sel_now = '0;
        if (fwd_valid && fwd_kind == BEAT_ADDR) begin
            for (int i = 0; i < `BUS_NUM_TARGETS; i++) begin
                sel_now[i] = (i == int'(fwd_word.addr.tsel));
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sel_q <= '0;
        end else if (txn_done) begin
            sel_q <= '0;
        end else if (sel_now != '0) begin
            sel_q <= sel_now;
        end
    end

    // Live during the address beat, held afterwards
    assign tsel_valid = sel_q | sel_now;

endmodule

// File: logic/response_router.sv
`include "bus_defines.svh"

module response_router import owner_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`BUS_NUM_TARGETS-1:0] tsel_valid,
    input  owner_t                      owner,
    input  logic                        resp_ack1,
    input  logic [`BUS_DATA_W-1:0]      resp_data1,
    input  logic                        resp_valid1,
    input  logic                        resp_ack2,
    input  logic [`BUS_DATA_W-1:0]      resp_data2,
    input  logic                        resp_valid2,
    output logic                        ret_ack1,
    output logic [`BUS_DATA_W-1:0]      ret_data1,
    output logic                        ret_valid1,
    output logic                        ret_ack2,
    output logic [`BUS_DATA_W-1:0]      ret_data2,
    output logic                        ret_valid2,
    output logic                        txn_done
);

    logic                   sel_ack;
    logic [`BUS_DATA_W-1:0] sel_data;
    logic                   sel_valid;

    // Response of the held target
    always_comb begin
        sel_ack   = 1'b0;
        sel_data  = '0;
        sel_valid = 1'b0;
        if (tsel_valid[0]) begin
            sel_ack   = resp_ack1;
            sel_data  = resp_data1;
            sel_valid = resp_valid1;
        end else if (tsel_valid[1]) begin
            sel_ack   = resp_ack2;
            sel_data  = resp_data2;
            sel_valid = resp_valid2;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            txn_done   <= 1'b0;
            ret_ack1   <= 1'b0;
            ret_valid1 <= 1'b0;
            ret_ack2   <= 1'b0;
            ret_valid2 <= 1'b0;
        end else begin
            txn_done   <= sel_ack;
            ret_ack1   <= sel_ack && (owner == OWNER_INIT1);
            ret_valid1 <= sel_ack && sel_valid && (owner == OWNER_INIT1);
            ret_ack2   <= sel_ack && (owner == OWNER_INIT2);
            ret_valid2 <= sel_ack && sel_valid && (owner == OWNER_INIT2);
        end
    end

    always_ff @(posedge clk) begin
        if (sel_ack && owner == OWNER_INIT1) ret_data1 <= sel_data;
        if (sel_ack && owner == OWNER_INIT2) ret_data2 <= sel_data;
    end

endmodule

// File: logic/target_port.sv
`include "bus_defines.svh"

module target_port import bus_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sel,
    input  bus_word_u              fwd_word,
    input  beat_kind_t             fwd_kind,
    input  logic                   fwd_valid,
    input  logic                   fwd_rw,
    input  logic                   target_ack,
    input  logic [`BUS_DATA_W-1:0] target_data_out,
    input  logic                   target_data_out_valid,
    output logic [`BUS_ADDR_W-1:0] target_addr_in,
    output logic                   target_addr_in_valid,
    output logic [`BUS_DATA_W-1:0] target_data_in,
    output logic                   target_data_in_valid,
    output logic                   target_rw,
    output logic                   resp_ack,
    output logic [`BUS_DATA_W-1:0] resp_data,
    output logic                   resp_valid
);

    logic addr_beat;
    logic data_beat;
    logic rw_q;

    assign addr_beat = sel && fwd_valid && (fwd_kind == BEAT_ADDR);
    assign data_beat = sel && fwd_valid && (fwd_kind == BEAT_DATA);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            target_addr_in_valid <= 1'b0;
            target_data_in_valid <= 1'b0;
            rw_q                 <= 1'b0;
        end else begin
            target_addr_in_valid <= addr_beat;
            target_data_in_valid <= data_beat;
            if (addr_beat) rw_q <= fwd_rw;
        end
    end

    always_ff @(posedge clk) begin
        if (addr_beat) target_addr_in <= {fwd_word.addr.tsel, fwd_word.addr.offset};
        if (data_beat) target_data_in <= fwd_word.data.data;
    end

    assign target_rw = sel && rw_q;

    // Return path only while this target is selected
    assign resp_ack   = sel && target_ack;
    assign resp_valid = sel && target_data_out_valid;
    assign resp_data  = sel ? target_data_out : '0;

endmodule

// File: logic/bus_top.sv
`include "bus_defines.svh"

module bus_top import bus_pkg::*, owner_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   init1_req,
    input  logic [`BUS_ADDR_W-1:0] init1_addr,
    input  logic [`BUS_DATA_W-1:0] init1_data,
    input  logic                   init1_rw,
    output logic                   init1_grant,
    output logic                   init1_ack,
    output logic [`BUS_DATA_W-1:0] init1_data_in,
    output logic                   init1_data_in_valid,

    input  logic                   init2_req,
    input  logic [`BUS_ADDR_W-1:0] init2_addr,
    input  logic [`BUS_DATA_W-1:0] init2_data,
    input  logic                   init2_rw,
    output logic                   init2_grant,
    output logic                   init2_ack,
    output logic [`BUS_DATA_W-1:0] init2_data_in,
    output logic                   init2_data_in_valid,

    output logic [`BUS_ADDR_W-1:0] target1_addr_in,
    output logic                   target1_addr_in_valid,
    output logic [`BUS_DATA_W-1:0] target1_data_in,
    output logic                   target1_data_in_valid,
    output logic                   target1_rw,
    input  logic                   target1_ack,
    input  logic [`BUS_DATA_W-1:0] target1_data_out,
    input  logic                   target1_data_out_valid,

    output logic [`BUS_ADDR_W-1:0] target2_addr_in,
    output logic                   target2_addr_in_valid,
    output logic [`BUS_DATA_W-1:0] target2_data_in,
    output logic                   target2_data_in_valid,
    output logic                   target2_rw,
    input  logic                   target2_ack,
    input  logic [`BUS_DATA_W-1:0] target2_data_out,
    input  logic                   target2_data_out_valid
);

    // Per-initiator forward fields
    logic       arb_req1, arb_req2;
    bus_word_u  fwd_word1, fwd_word2;
    beat_kind_t fwd_kind1, fwd_kind2;
    logic       fwd_valid1, fwd_valid2;
    logic       fwd_rw1, fwd_rw2;
    logic       grant1, grant2;

    // Shared forward bus
    bus_word_u  fwd_word;
    beat_kind_t fwd_kind;
    logic       fwd_valid;
    logic       fwd_rw;
    owner_t     owner;

    logic [`BUS_NUM_TARGETS-1:0] tsel_valid;
    logic                        txn_done;

    // Return path
    logic                   resp_ack1, resp_valid1, resp_ack2, resp_valid2;
    logic [`BUS_DATA_W-1:0] resp_data1, resp_data2;
    logic                   ret_ack1, ret_valid1, ret_ack2, ret_valid2;
    logic [`BUS_DATA_W-1:0] ret_data1, ret_data2;

    init_port u_init_port_1 (
        .clk(clk), .rst_n(rst_n),
        .req(init1_req), .addr(init1_addr), .data(init1_data), .rw(init1_rw),
        .grant(grant1), .arb_req(arb_req1),
        .fwd_word(fwd_word1), .fwd_kind(fwd_kind1),
        .fwd_valid(fwd_valid1), .fwd_rw(fwd_rw1),
        .init_grant(init1_grant), .init_ack(init1_ack),
        .init_data_in(init1_data_in), .init_data_in_valid(init1_data_in_valid),
        .ret_ack(ret_ack1), .ret_data(ret_data1), .ret_valid(ret_valid1)
    );

    init_port u_init_port_2 (
        .clk(clk), .rst_n(rst_n),
        .req(init2_req), .addr(init2_addr), .data(init2_data), .rw(init2_rw),
        .grant(grant2), .arb_req(arb_req2),
        .fwd_word(fwd_word2), .fwd_kind(fwd_kind2),
        .fwd_valid(fwd_valid2), .fwd_rw(fwd_rw2),
        .init_grant(init2_grant), .init_ack(init2_ack),
        .init_data_in(init2_data_in), .init_data_in_valid(init2_data_in_valid),
        .ret_ack(ret_ack2), .ret_data(ret_data2), .ret_valid(ret_valid2)
    );

    bus_arbiter u_bus_arbiter (
        .clk(clk), .rst_n(rst_n),
        .arb_req1(arb_req1), .fwd_word1(fwd_word1), .fwd_kind1(fwd_kind1),
        .fwd_valid1(fwd_valid1), .fwd_rw1(fwd_rw1),
        .arb_req2(arb_req2), .fwd_word2(fwd_word2), .fwd_kind2(fwd_kind2),
        .fwd_valid2(fwd_valid2), .fwd_rw2(fwd_rw2),
        .txn_done(txn_done),
        .grant1(grant1), .grant2(grant2), .owner(owner),
        .fwd_word(fwd_word), .fwd_kind(fwd_kind),
        .fwd_valid(fwd_valid), .fwd_rw(fwd_rw)
    );

    addr_decoder u_addr_decoder (
        .clk(clk), .rst_n(rst_n),
        .fwd_word(fwd_word), .fwd_kind(fwd_kind), .fwd_valid(fwd_valid),
        .txn_done(txn_done), .tsel_valid(tsel_valid)
    );

    target_port u_target_port_1 (
        .clk(clk), .rst_n(rst_n), .sel(tsel_valid[0]),
        .fwd_word(fwd_word), .fwd_kind(fwd_kind),
        .fwd_valid(fwd_valid), .fwd_rw(fwd_rw),
        .target_ack(target1_ack), .target_data_out(target1_data_out),
        .target_data_out_valid(target1_data_out_valid),
        .target_addr_in(target1_addr_in), .target_addr_in_valid(target1_addr_in_valid),
        .target_data_in(target1_data_in), .target_data_in_valid(target1_data_in_valid),
        .target_rw(target1_rw),
        .resp_ack(resp_ack1), .resp_data(resp_data1), .resp_valid(resp_valid1)
    );

    target_port u_target_port_2 (
        .clk(clk), .rst_n(rst_n), .sel(tsel_valid[1]),
        .fwd_word(fwd_word), .fwd_kind(fwd_kind),
        .fwd_valid(fwd_valid), .fwd_rw(fwd_rw),
        .target_ack(target2_ack), .target_data_out(target2_data_out),
        .target_data_out_valid(target2_data_out_valid),
        .target_addr_in(target2_addr_in), .target_addr_in_valid(target2_addr_in_valid),
        .target_data_in(target2_data_in), .target_data_in_valid(target2_data_in_valid),
        .target_rw(target2_rw),
        .resp_ack(resp_ack2), .resp_data(resp_data2), .resp_valid(resp_valid2)
    );

    response_router u_response_router (
        .clk(clk), .rst_n(rst_n),
        .tsel_valid(tsel_valid), .owner(owner),
        .resp_ack1(resp_ack1), .resp_data1(resp_data1), .resp_valid1(resp_valid1),
        .resp_ack2(resp_ack2), .resp_data2(resp_data2), .resp_valid2(resp_valid2),
        .ret_ack1(ret_ack1), .ret_data1(ret_data1), .ret_valid1(ret_valid1),
        .ret_ack2(ret_ack2), .ret_data2(ret_data2), .ret_valid2(ret_valid2),
        .txn_done(txn_done)
    );

endmodule

// File: tb/bus_props.sv
module bus_props (
    input logic clk,
    input logic rst_n,
    input logic init1_grant,
    input logic init2_grant,
    input logic init1_ack,
    input logic init2_ack,
    input logic target1_addr_in_valid,
    input logic target2_addr_in_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // Owner keeps the bus until its ack
    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(init1_grant) |-> $past(init1_ack))
        else $error("initiator 1 lost its grant before the ack");

    assert property (@(posedge clk) disable iff (!rst_n)
        $fell(init2_grant) |-> $past(init2_ack))
        else $error("initiator 2 lost its grant before the ack");

    assert property (@(posedge clk) disable iff (!rst_n)
        !(target1_addr_in_valid && target2_addr_in_valid))
        else $error("address delivered to both targets");

    // Ack returns only to the owner
    assert property (@(posedge clk) disable iff (!rst_n)
        init1_ack |-> init1_grant)
        else $error("initiator 1 ack without grant");

    assert property (@(posedge clk) disable iff (!rst_n)
        init2_ack |-> init2_grant)
        else $error("initiator 2 ack without grant");

endmodule

bind bus_top bus_props u_bus_props (
    .clk(clk),
    .rst_n(rst_n),
    .init1_grant(init1_grant),
    .init2_grant(init2_grant),
    .init1_ack(init1_ack),
    .init2_ack(init2_ack),
    .target1_addr_in_valid(target1_addr_in_valid),
    .target2_addr_in_valid(target2_addr_in_valid)
);

// File: tb/bus_tb.sv
`include "bus_defines.svh"

module bus_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RST_CYCLES = 8;
    localparam int NUM_RAND = 200;
    localparam int PER_INIT = NUM_RAND / 2;
    localparam int NUM_DIRECTED = 4;
    localparam int TIMEOUT_CYCLES = RST_CYCLES + (NUM_RAND + NUM_DIRECTED) * 20;
    localparam logic [`BUS_DATA_W-1:0] RD_XOR = 8'h5C;

    typedef struct packed {
        logic                   rw;
        logic [`BUS_ADDR_W-1:0] addr;
        logic [`BUS_DATA_W-1:0] data;
    } access_t;

    logic clk = 1'b0;
    logic rst_n;

    // Initiator pins, index 0 is initiator 1
    logic [1:0]             i_req;
    logic [1:0]             i_rw;
    logic [`BUS_ADDR_W-1:0] i_addr [2];
    logic [`BUS_DATA_W-1:0] i_data [2];
    wire  [1:0]             i_grant;
    wire  [1:0]             i_ack;
    wire  [1:0]             i_dvalid;
    wire  [`BUS_DATA_W-1:0] i_rdata [2];

    // Target pins, index 0 is target 1
    wire  [`BUS_ADDR_W-1:0] t_addr [2];
    wire  [1:0]             t_avalid;
    wire  [`BUS_DATA_W-1:0] t_wdata [2];
    wire  [1:0]             t_dvalid_in;
    wire  [1:0]             t_rw;
    logic [1:0]             t_ack;
    logic [`BUS_DATA_W-1:0] t_rdata [2];
    logic [1:0]             t_rvalid;

    logic [31:0]            lfsr;
    logic [`BUS_ADDR_W-1:0] r_addr [2][PER_INIT];
    logic [`BUS_DATA_W-1:0] r_data [2][PER_INIT];
    logic                   r_rw [2][PER_INIT];
    int                     r_gap [2][PER_INIT];
    int                     ack_delay [2][256];

    // Reference model state
    access_t                pend [2];
    logic [1:0]             outstanding;
    access_t                exp_q [$];
    logic [`BUS_ADDR_W-1:0] access_log [$];
    int                     req_count [2];
    int                     ack_count [2];
    int                     acc_total;

    string test_name;
    int    err_count;
    int    check_count;
    int    test_count;
    int    test_errs;

    bus_top dut (
        .clk(clk), .rst_n(rst_n),
        .init1_req(i_req[0]), .init1_addr(i_addr[0]), .init1_data(i_data[0]),
        .init1_rw(i_rw[0]), .init1_grant(i_grant[0]), .init1_ack(i_ack[0]),
        .init1_data_in(i_rdata[0]), .init1_data_in_valid(i_dvalid[0]),
        .init2_req(i_req[1]), .init2_addr(i_addr[1]), .init2_data(i_data[1]),
        .init2_rw(i_rw[1]), .init2_grant(i_grant[1]), .init2_ack(i_ack[1]),
        .init2_data_in(i_rdata[1]), .init2_data_in_valid(i_dvalid[1]),
        .target1_addr_in(t_addr[0]), .target1_addr_in_valid(t_avalid[0]),
        .target1_data_in(t_wdata[0]), .target1_data_in_valid(t_dvalid_in[0]),
        .target1_rw(t_rw[0]), .target1_ack(t_ack[0]),
        .target1_data_out(t_rdata[0]), .target1_data_out_valid(t_rvalid[0]),
        .target2_addr_in(t_addr[1]), .target2_addr_in_valid(t_avalid[1]),
        .target2_data_in(t_wdata[1]), .target2_data_in_valid(t_dvalid_in[1]),
        .target2_rw(t_rw[1]), .target2_ack(t_ack[1]),
        .target2_data_out(t_rdata[1]), .target2_data_out_valid(t_rvalid[1])
    );

    always #20 clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [15:0] rand_bits(input int nbits);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic gen_stimulus();
        logic [15:0] tmp;
        for (int n = 0; n < 2; n++) begin
            for (int i = 0; i < PER_INIT; i++) begin
                r_addr[n][i] = rand_bits(16);
                tmp = rand_bits(8);
                r_data[n][i] = tmp[7:0];
                tmp = rand_bits(1);
                r_rw[n][i] = tmp[0];
                tmp = rand_bits(2);
                r_gap[n][i] = int'(tmp[1:0]);
            end
        end
        for (int m = 0; m < 2; m++) begin
            for (int i = 0; i < 256; i++) begin
                tmp = rand_bits(2);
                ack_delay[m][i] = 1 + int'(tmp[1:0]);
            end
        end
    endtask

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = err_count;
    endtask

    task automatic end_test();
        for (int n = 0; n < 2; n++) begin
            check_value({test_name, " ack count"}, 16'(req_count[n]), 16'(ack_count[n]));
        end
        check_value({test_name, " unserved grants"}, 16'h0000, 16'(exp_q.size()));
        test_count++;
        $display("test %s finished with %0d errors", test_name, err_count - test_errs);
    endtask

    // One request from initiator n, held until its ack
    task automatic run_txn(input int n, input logic [15:0] a, input logic [7:0] d,
                           input logic w);
        @(posedge clk);
        #2;
        i_req[n] = 1'b1;
        i_addr[n] = a;
        i_data[n] = d;
        i_rw[n] = w;
        pend[n].rw = w;
        pend[n].addr = a;
        pend[n].data = d;
        outstanding[n] = 1'b1;
        req_count[n]++;
        @(negedge clk);
        while (!i_ack[n]) @(negedge clk);
        check_value({test_name, " read valid"}, 16'(!w), 16'(i_dvalid[n]));
        if (!w) begin
            check_value({test_name, " read data"}, 16'(a[7:0] ^ RD_XOR), 16'(i_rdata[n]));
        end
        @(posedge clk);
        #2;
        i_req[n] = 1'b0;
        outstanding[n] = 1'b0;
    endtask

    task automatic run_random(input int n);
        for (int i = 0; i < PER_INIT; i++) begin
            repeat (r_gap[n][i]) @(posedge clk);
            run_txn(n, r_addr[n][i], r_data[n][i], r_rw[n][i]);
        end
    endtask

    task automatic record_access(input int m, input logic [15:0] a, input logic w,
                                 input logic [7:0] d);
        access_t e;
        acc_total++;
        access_log.push_back(a);
        if (exp_q.size() == 0) begin
            $display("target %0d saw an access that no grant explains", m + 1);
            err_count++;
        end else begin
            e = exp_q.pop_front();
            check_value({test_name, " target"}, 16'(e.addr[`BUS_TSEL_BIT]), 16'(m));
            check_value({test_name, " addr"}, e.addr, a);
            check_value({test_name, " rw"}, 16'(e.rw), 16'(w));
            if (w) begin
                check_value({test_name, " write data"}, 16'(e.data), 16'(d));
            end
        end
    endtask

    // Target model, acks 1 to 4 cycles after the last beat
    task automatic serve_target(input int m);
        logic [15:0] a;
        logic        w;
        logic [7:0]  d;
        int          idx;
        idx = 0;
        forever begin
            @(negedge clk);
            if (t_avalid[m]) begin
                a = t_addr[m];
                w = t_rw[m];
                d = 8'h00;
                if (w) begin
                    @(negedge clk);
                    while (!t_dvalid_in[m]) @(negedge clk);
                    d = t_wdata[m];
                end
                record_access(m, a, w, d);
                repeat (ack_delay[m][idx % 256]) @(posedge clk);
                #2;
                t_ack[m] = 1'b1;
                t_rvalid[m] = !w;
                t_rdata[m] = w ? 8'h00 : (a[7:0] ^ RD_XOR);
                @(posedge clk);
                #2;
                t_ack[m] = 1'b0;
                t_rvalid[m] = 1'b0;
                idx++;
            end
        end
    endtask

    // Arbitration order feeds the expected access queue
    task automatic watch_bus();
        logic [1:0] prev;
        prev = 2'b00;
        forever begin
            @(negedge clk);
            for (int n = 0; n < 2; n++) begin
                if (i_grant[n] && !prev[n]) begin
                    if (outstanding[n]) begin
                        exp_q.push_back(pend[n]);
                    end else begin
                        $display("initiator %0d was granted without a request", n + 1);
                        err_count++;
                    end
                end
                if (i_ack[n]) begin
                    ack_count[n]++;
                    if (!outstanding[n]) begin
                        $display("initiator %0d got an ack it did not ask for", n + 1);
                        err_count++;
                    end
                end
            end
            prev = i_grant;
        end
    endtask

    initial begin
        rst_n = 1'b0;
        i_req = 2'b00;
        i_rw = 2'b00;
        t_ack = 2'b00;
        t_rvalid = 2'b00;
        outstanding = 2'b00;
        for (int n = 0; n < 2; n++) begin
            i_addr[n] = '0;
            i_data[n] = '0;
            t_rdata[n] = '0;
            req_count[n] = 0;
            ack_count[n] = 0;
        end
        acc_total = 0;
        err_count = 0;
        check_count = 0;
        test_count = 0;
        lfsr = 32'd92584;
        gen_stimulus();
        fork
            serve_target(0);
            serve_target(1);
            watch_bus();
        join_none
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;

        start_test("reset_idle");
        repeat (3) begin
            @(negedge clk);
            check_value("reset_idle outputs", 16'h0000,
                        16'({i_grant, i_ack, i_dvalid, t_avalid, t_dvalid_in}));
        end
        end_test();

        start_test("write_to_target2");
        run_txn(0, 16'hA5C3, 8'h3C, 1'b1);
        end_test();

        start_test("read_from_target1");
        run_txn(1, 16'h1234, 8'h00, 1'b0);
        end_test();

        // Same-cycle requests, initiator 1 must go first
        start_test("same_cycle_requests");
        access_log.delete();
        fork
            run_txn(0, 16'h0042, 8'h00, 1'b0);
            run_txn(1, 16'hC0DE, 8'h5A, 1'b1);
        join
        check_value("same_cycle_requests count", 16'd2, 16'(access_log.size()));
        if (access_log.size() == 2) begin
            check_value("same_cycle_requests first", 16'h0042, access_log[0]);
            check_value("same_cycle_requests second", 16'hC0DE, access_log[1]);
        end
        end_test();

        start_test("random_traffic");
        acc_total = 0;
        fork
            run_random(0);
            run_random(1);
        join
        check_value("random_traffic accesses", 16'(NUM_RAND), 16'(acc_total));
        end_test();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: transactions stopped completing on the bus");
        $display("sim failed");
        $finish;
    end

endmodule

// File: src.f
+incdir+logic
logic/bus_pkg.sv
logic/owner_pkg.sv
logic/init_port.sv
logic/bus_arbiter.sv
logic/addr_decoder.sv
logic/response_router.sv
logic/target_port.sv
logic/bus_top.sv
tb/bus_props.sv
tb/bus_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module bus_tb -f src.f

result=$(./obj_dir/Vbus_tb 2>&1) || true
printf '%s\n' "$result"
printf '%s\n' "$result" | grep -qx 'sim passed'
